//--- logic/fetch_pkg.sv
// Widths, reset PC and the three-opcode encoding shared by the fetch front end
// Addresses never fault; any address wraps into the instruction memory through its index field
package fetch_pkg;

    // Machine word, used for both fetch addresses and instructions
    localparam int WORD_W = 32;
    typedef logic [WORD_W-1:0] word_t;

    // First address fetched once reset is released
    localparam word_t RESET_PC = 32'h0000_0100;

    // Instruction memory geometry
    localparam int IMEM_DEPTH = 256;
    localparam int IMEM_AW = $clog2(IMEM_DEPTH);

    // Word index taken from the byte address
    // With 256 words this is bits 9:2, and the upper bits are ignored
    localparam int IDX_LSB = 2;
    localparam int IDX_MSB = IDX_LSB + IMEM_AW - 1;

    // Opcode field sits in the top nibble of the instruction
    localparam int OP_MSB = 31;
    localparam int OP_LSB = 28;
    localparam int OP_W = OP_MSB - OP_LSB + 1;

    // Control-flow opcodes
    // Values other than these three are treated as plain
    localparam logic [OP_W-1:0] OP_PLAIN = 4'd0;
    localparam logic [OP_W-1:0] OP_JUMP = 4'd1;
    localparam logic [OP_W-1:0] OP_HALT = 4'd2;

    // Jump offset in the low half of the word
    // It counts words, signed, relative to the PC of the jump itself
    localparam int IMM_MSB = 15;
    localparam int IMM_LSB = 0;
    localparam int IMM_W = IMM_MSB - IMM_LSB + 1;

    // Byte shift that turns a word count into an address offset
    localparam int WORD_SHIFT = 2;

    // Bits needed to sign-extend the shifted offset up to a full word
    localparam int IMM_EXT_W = WORD_W - IMM_W - WORD_SHIFT;

endpackage : fetch_pkg

//--- logic/fetch_stage.sv
// Fetch stage for a memory that answers in the same cycle as the address
// Only a reset leaves HALT; a trap while halted is ignored
`timescale 1ns/1ns

module fetch_stage (
    input  logic              clk,
    input  logic              rst_n,

    // Fetch port to the instruction memory
    output logic              fetch_valid,
    output fetch_pkg::word_t  fetch_addr,
    input  logic              fetch_ready,
    input  fetch_pkg::word_t  fetch_instr,

    // Fetched instruction towards s2
    output logic              id_valid,
    output fetch_pkg::word_t  id_pc,
    output fetch_pkg::word_t  id_instr,

    // Feedback from s2
    input  logic              s2_busy,
    input  logic              branch_en,
    input  fetch_pkg::word_t  branch_target,
    input  logic              halt_req,

    // Trap redirect, a single-cycle pulse
    input  logic              trap_occurred,
    input  fetch_pkg::word_t  trap_target
);

    typedef enum logic [1:0] {
        INIT,
        FETCHING,
        HALT
    } state_e;

    state_e state_ff;
    state_e next_state;

    fetch_pkg::word_t pc_ff;
    fetch_pkg::word_t next_pc;
    fetch_pkg::word_t redirect_pc;

    fetch_pkg::word_t id_pc_ff;
    fetch_pkg::word_t id_instr_ff;
    logic             id_valid_ff;

    logic flush;
    logic stall;
    logic transfer;
    logic take;

    // A flush throws away whatever s1 holds, so it overrides any stall
    assign flush = trap_occurred || branch_en;
    assign stall = !flush && (!fetch_ready || s2_busy);

    assign transfer = fetch_valid && fetch_ready;
    // The output register is written only by a fetch that is not held back
    assign take = transfer && !stall;

    // Trap beats branch; the two never meet since s2 blocks acceptance during a trap
    assign redirect_pc = trap_occurred ? trap_target : branch_target;

    // pc_ff is the address still to be fetched
    // A redirect is bypassed straight onto the fetch port, so the target goes out this cycle
    assign fetch_addr = flush ? redirect_pc : pc_ff;

    // Step past the fetched word when it is taken, otherwise keep pointing at it
    // After an untaken redirect this leaves the target in pc_ff for a retry
    assign next_pc = take ? fetch_addr + 32'd4 : fetch_addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_ff <= fetch_pkg::RESET_PC;
        end else if (state_ff != HALT) begin
            pc_ff <= next_pc;
        end
    end

    // Valid bit of the output register
    // While s2 is busy the presented instruction stays put until s2 takes it
    // Otherwise the presented one was consumed, and it is dropped unless a new one replaces it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid_ff <= 1'b0;
        end else if (take) begin
            id_valid_ff <= 1'b1;
        end else if (flush || !s2_busy) begin
            id_valid_ff <= 1'b0;
        end
    end

    // Payload of the output register, the fetched word and the address it came from
    always_ff @(posedge clk) begin
        if (take) begin
            id_pc_ff    <= fetch_addr;
            id_instr_ff <= fetch_instr;
        end
    end

    assign id_pc    = id_pc_ff;
    assign id_instr = id_instr_ff;

    // A branch only ever comes from the instruction being presented, so only a trap masks it
    assign id_valid = id_valid_ff && !trap_occurred;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_ff <= INIT;
        end else begin
            state_ff <= next_state;
        end
    end

    always_comb begin
        unique case (state_ff)
            INIT: begin
                // Wait here until the memory completes the first fetch
                if (fetch_ready) begin
                    next_state = FETCHING;
                end else begin
                    next_state = INIT;
                end
            end
            FETCHING: begin
                // s2 retired a halt instruction
                if (halt_req) begin
                    next_state = HALT;
                end else begin
                    next_state = FETCHING;
                end
            end
            HALT: next_state = HALT;
            // An unused encoding parks the front end
            default: next_state = HALT;
        endcase
    end

    // Fetching is requested in every state but HALT
    assign fetch_valid = (state_ff != HALT);

    // A fetch the memory has not finished keeps its address until it completes or a redirect
    addr_hold_on_wait: assert property (
        @(posedge clk) disable iff (!rst_n)
        fetch_valid && !fetch_ready && !flush |=> flush || $stable(fetch_addr)
    );

    // The redirect mux expects s2 to stay quiet during a trap
    redirect_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(branch_en && trap_occurred)
    );

endmodule : fetch_stage

//--- logic/instr_mem.sv
// Word-addressed instruction memory, read in the same cycle as the address
// Contents are undefined until loaded; the upper address bits are ignored
`timescale 1ns/1ns

module instr_mem (
    input  logic              clk,

    // Fetch port from s1
    input  logic              fetch_valid,
    input  fetch_pkg::word_t  fetch_addr,
    output logic              fetch_ready,
    output fetch_pkg::word_t  fetch_instr,

    // Stall request from outside, holds off any fetch while high
    input  logic              imem_stall,

    // Program load port, one word per cycle
    input  logic              load_en,
    input  fetch_pkg::word_t  load_addr,
    input  fetch_pkg::word_t  load_data
);

    // Storage for the whole program
    fetch_pkg::word_t mem [fetch_pkg::IMEM_DEPTH];

    logic [fetch_pkg::IMEM_AW-1:0] rd_idx;
    logic [fetch_pkg::IMEM_AW-1:0] wr_idx;

    // Both ports index by word, so any byte address wraps into the array
    assign rd_idx = fetch_addr[fetch_pkg::IDX_MSB:fetch_pkg::IDX_LSB];
    assign wr_idx = load_addr[fetch_pkg::IDX_MSB:fetch_pkg::IDX_LSB];

    // Loads land on the clock edge
    // A fetch to the same word in that cycle still sees the old contents
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[wr_idx] <= load_data;
        end
    end

    // Read path is purely combinational
    assign fetch_instr = mem[rd_idx];

    // The memory answers any request at once unless it is told to stall
    assign fetch_ready = fetch_valid && !imem_stall;

    // Every address s1 sends, sequential or redirected, lands on a word boundary
    fetch_addr_aligned: assert property (
        @(posedge clk)
        fetch_valid |-> (fetch_addr[fetch_pkg::IDX_LSB-1:0] == '0)
    );

endmodule : instr_mem

//--- logic/branch_unit.sv
// Second stage that takes fetched instructions, resolves jump and halt and reports retirements
// Once a halt retires nothing more is taken until reset
`timescale 1ns/1ns

module branch_unit (
    input  logic              clk,
    input  logic              rst_n,

    // Instruction presented by s1
    input  logic              id_valid,
    input  fetch_pkg::word_t  id_pc,
    input  fetch_pkg::word_t  id_instr,

    // Back-pressure from outside and the trap pulse
    input  logic              s2_hold,
    input  logic              trap_occurred,

    // Feedback to s1
    output logic              s2_busy,
    output logic              branch_en,
    output fetch_pkg::word_t  branch_target,
    output logic              halt_req,

    // Retired instruction stream
    output logic              retire_valid,
    output fetch_pkg::word_t  retire_pc,
    output fetch_pkg::word_t  retire_instr
);

    logic [fetch_pkg::OP_W-1:0]  opcode;
    logic [fetch_pkg::IMM_W-1:0] imm;
    fetch_pkg::word_t            offset_bytes;

    logic accept;
    logic is_jump;
    logic is_halt;
    logic halted_ff;

    // A trap takes the instruction away from s2, so it is never accepted alongside one
    assign accept = id_valid && !s2_hold && !trap_occurred && !halted_ff;

    assign opcode = id_instr[fetch_pkg::OP_MSB:fetch_pkg::OP_LSB];
    assign imm    = id_instr[fetch_pkg::IMM_MSB:fetch_pkg::IMM_LSB];

    always_comb begin
        case (opcode)
            fetch_pkg::OP_JUMP: begin
                is_jump = 1'b1;
                is_halt = 1'b0;
            end
            fetch_pkg::OP_HALT: begin
                is_jump = 1'b0;
                is_halt = 1'b1;
            end
            // Plain and every unused opcode
            default: begin
                is_jump = 1'b0;
                is_halt = 1'b0;
            end
        endcase
    end

    // Word offset sign-extended and scaled to bytes
    assign offset_bytes = {{fetch_pkg::IMM_EXT_W{imm[fetch_pkg::IMM_W-1]}}, imm,
                           {fetch_pkg::WORD_SHIFT{1'b0}}};

    assign branch_target = id_pc + offset_bytes;

    // Redirect goes out in the same cycle the jump is taken
    assign branch_en = accept && is_jump;

    // Sticky halt that rises the cycle after the halt instruction is taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted_ff <= 1'b0;
        end else if (accept && is_halt) begin
            halted_ff <= 1'b1;
        end
    end

    assign halt_req = halted_ff;

    // s1 sees the external hold as s2 being busy
    assign s2_busy = s2_hold;

    // Each accepted instruction retires right away
    assign retire_valid = accept;
    assign retire_pc    = id_pc;
    assign retire_instr = id_instr;

endmodule : branch_unit

//--- logic/fetch_top.sv
// Fetch front end: s1, instruction memory and s2 wired together
// The program must be loaded through the load port while imem_stall is held high
`timescale 1ns/1ns

module fetch_top (
    input  logic              clk,
    input  logic              rst_n,

    // Outside control of the pipeline
    input  logic              imem_stall,
    input  logic              s2_hold,
    input  logic              trap_occurred,
    input  fetch_pkg::word_t  trap_target,

    // Program load port
    input  logic              load_en,
    input  fetch_pkg::word_t  load_addr,
    input  fetch_pkg::word_t  load_data,

    // Retirement and status
    output logic              retire_valid,
    output fetch_pkg::word_t  retire_pc,
    output fetch_pkg::word_t  retire_instr,
    output logic              halt_req,
    output logic              fetch_valid
);

    // Fetch port between s1 and the memory
    fetch_pkg::word_t fetch_addr;
    logic             fetch_ready;
    fetch_pkg::word_t fetch_instr;

    // s1 to s2
    logic             id_valid;
    fetch_pkg::word_t id_pc;
    fetch_pkg::word_t id_instr;

    // s2 back to s1
    logic             s2_busy;
    logic             branch_en;
    fetch_pkg::word_t branch_target;

    fetch_stage i_fetch_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_valid   (fetch_valid),
        .fetch_addr    (fetch_addr),
        .fetch_ready   (fetch_ready),
        .fetch_instr   (fetch_instr),
        .id_valid      (id_valid),
        .id_pc         (id_pc),
        .id_instr      (id_instr),
        .s2_busy       (s2_busy),
        .branch_en     (branch_en),
        .branch_target (branch_target),
        .halt_req      (halt_req),
        .trap_occurred (trap_occurred),
        .trap_target   (trap_target)
    );

    instr_mem i_instr_mem (
        .clk         (clk),
        .fetch_valid (fetch_valid),
        .fetch_addr  (fetch_addr),
        .fetch_ready (fetch_ready),
        .fetch_instr (fetch_instr),
        .imem_stall  (imem_stall),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data)
    );

    branch_unit i_branch_unit (
        .clk           (clk),
        .rst_n         (rst_n),
        .id_valid      (id_valid),
        .id_pc         (id_pc),
        .id_instr      (id_instr),
        .s2_hold       (s2_hold),
        .trap_occurred (trap_occurred),
        .s2_busy       (s2_busy),
        .branch_en     (branch_en),
        .branch_target (branch_target),
        .halt_req      (halt_req),
        .retire_valid  (retire_valid),
        .retire_pc     (retire_pc),
        .retire_instr  (retire_instr)
    );

endmodule : fetch_top

//--- sim/fetch_ref_model.svh
// Reference model for the fetch front end, included inside the testbench module
// It keeps its own program image and walks the expected PC by the opcode rules
`ifndef FETCH_REF_MODEL_SVH
`define FETCH_REF_MODEL_SVH

// Program image as written into the DUT, one entry per memory word
fetch_pkg::word_t image [fetch_pkg::IMEM_DEPTH];

// Address of the next instruction expected to retire
fetch_pkg::word_t exp_pc;

// Word that holds the single halt instruction
int halt_index;

// Any byte address lands on a word of the array, the upper bits wrap away
function automatic int word_index(fetch_pkg::word_t addr);
    return int'((addr >> 2) % fetch_pkg::IMEM_DEPTH);
endfunction

function automatic logic [3:0] opcode_of(fetch_pkg::word_t instr);
    return instr[fetch_pkg::OP_MSB:fetch_pkg::OP_LSB];
endfunction

// Address that follows an instruction once it retires
// A jump adds its signed word count times four, anything else steps one word
function automatic fetch_pkg::word_t follow_pc(fetch_pkg::word_t pc,
                                              fetch_pkg::word_t instr);
    int offset_words;
    offset_words = int'($signed(instr[fetch_pkg::IMM_MSB:fetch_pkg::IMM_LSB]));
    if (opcode_of(instr) == fetch_pkg::OP_JUMP) begin
        return pc + fetch_pkg::word_t'(offset_words * 4);
    end
    return pc + 32'd4;
endfunction

// Random word whose opcode is neither jump nor halt
function automatic fetch_pkg::word_t plain_word();
    fetch_pkg::word_t w;
    w = $urandom;
    if (opcode_of(w) == fetch_pkg::OP_JUMP || opcode_of(w) == fetch_pkg::OP_HALT) begin
        w[fetch_pkg::OP_MSB:fetch_pkg::OP_LSB] = fetch_pkg::OP_PLAIN;
    end
    return w;
endfunction

// Jump with a random offset, never zero so it cannot spin on itself
function automatic fetch_pkg::word_t jump_word();
    fetch_pkg::word_t w;
    w = $urandom;
    w[fetch_pkg::OP_MSB:fetch_pkg::OP_LSB] = fetch_pkg::OP_JUMP;
    if (w[fetch_pkg::IMM_MSB:fetch_pkg::IMM_LSB] == '0) begin
        w[fetch_pkg::IMM_LSB] = 1'b1;
    end
    return w;
endfunction

function automatic fetch_pkg::word_t halt_word();
    fetch_pkg::word_t w;
    w = $urandom;
    w[fetch_pkg::OP_MSB:fetch_pkg::OP_LSB] = fetch_pkg::OP_HALT;
    return w;
endfunction

// Roughly one word in eight is a jump, and exactly one word is a halt
task automatic build_program();
    int i;
    for (i = 0; i < fetch_pkg::IMEM_DEPTH; i++) begin
        if ($urandom % 8 == 0) begin
            image[i] = jump_word();
        end else begin
            image[i] = plain_word();
        end
    end
    halt_index = $urandom % fetch_pkg::IMEM_DEPTH;
    // Keep the halt off the reset word so at least a few instructions run
    if (halt_index == word_index(fetch_pkg::RESET_PC)) begin
        halt_index = (halt_index + 1) % fetch_pkg::IMEM_DEPTH;
    end
    image[halt_index] = halt_word();
endtask

`endif

//--- sim/tb_fetch.sv
// Testbench for the fetch front end with random stalls, holds and trap pulses
// The run ends at the halt instruction or after a fixed number of retirements
`timescale 1ns/1ns

module tb_fetch;

    localparam int unsigned SEED = 32'h7838;
    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 3;
    localparam int MAX_RETIRE = 3000;
    localparam int RUN_CYCLES = 20000;
    localparam int HALT_WAIT = 4;
    localparam int QUIET_CYCLES = 50;

    logic             clk;
    logic             rst_n;
    logic             imem_stall;
    logic             s2_hold;
    logic             trap_occurred;
    fetch_pkg::word_t trap_target;
    logic             load_en;
    fetch_pkg::word_t load_addr;
    fetch_pkg::word_t load_data;

    logic             retire_valid;
    fetch_pkg::word_t retire_pc;
    fetch_pkg::word_t retire_instr;
    logic             halt_req;
    logic             fetch_valid;

    // Run bookkeeping
    logic halt_retired;
    int   retired_count;
    int   jump_count;
    int   trap_count;
    int   checks;
    int   errors;
    int   wait_cycles;

    `include "fetch_ref_model.svh"

    fetch_top i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .imem_stall    (imem_stall),
        .s2_hold       (s2_hold),
        .trap_occurred (trap_occurred),
        .trap_target   (trap_target),
        .load_en       (load_en),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .retire_valid  (retire_valid),
        .retire_pc     (retire_pc),
        .retire_instr  (retire_instr),
        .halt_req      (halt_req),
        .fetch_valid   (fetch_valid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Write the whole image, with random upper address bits that the memory must ignore
    task automatic load_program();
        int i;
        fetch_pkg::word_t high_bits;
        for (i = 0; i < fetch_pkg::IMEM_DEPTH; i++) begin
            high_bits = $urandom & ~fetch_pkg::word_t'(fetch_pkg::IMEM_DEPTH * 4 - 1);
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= fetch_pkg::word_t'(i * 4) | high_bits;
            load_data <= image[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    // Called right after a rising edge
    // Trap pulses last one cycle and start only once something has retired
    task automatic drive_random_inputs();
        imem_stall <= ($urandom % 100) < 30;
        s2_hold    <= ($urandom % 100) < 20;
        if (!trap_occurred && retired_count > 0 && $urandom % 32 == 0) begin
            trap_occurred <= 1'b1;
            trap_target   <= $urandom & 32'hFFFF_FFFC;
            trap_count++;
        end else begin
            trap_occurred <= 1'b0;
        end
    endtask

    // One clock with fresh stimulus that ends at the falling edge where outputs are settled
    task automatic step_cycle();
        @(posedge clk);
        drive_random_inputs();
        @(negedge clk);
    endtask

    // Compare one retirement with the model, then move the model past it
    task automatic check_retirement();
        fetch_pkg::word_t model_instr;
        model_instr = image[word_index(exp_pc)];
        if (halt_retired) begin
            errors++;
            $display("%0t: instruction at %h retired after the halt", $time, retire_pc);
        end
        if (retired_count == 0 && retire_pc !== fetch_pkg::RESET_PC) begin
            errors++;
            $display("[ERROR] %0t first retire_pc: got %h expected %h",
                     $time, retire_pc, fetch_pkg::RESET_PC);
        end
        checks += 2;
        if (retire_pc !== exp_pc) begin
            errors++;
            $display("[ERROR] %0t retire_pc: got %h expected %h", $time, retire_pc, exp_pc);
        end
        if (retire_instr !== model_instr) begin
            errors++;
            $display("[ERROR] %0t retire_instr: got %h expected %h",
                     $time, retire_instr, model_instr);
        end
        if (opcode_of(model_instr) == fetch_pkg::OP_JUMP) begin
            jump_count++;
        end
        if (opcode_of(model_instr) == fetch_pkg::OP_HALT) begin
            halt_retired = 1'b1;
        end
        exp_pc = follow_pc(exp_pc, model_instr);
        retired_count++;
    endtask

    // Inputs change only at rising edges, so the falling edge sees a settled cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (trap_occurred) begin
                checks++;
                if (retire_valid) begin
                    errors++;
                    $display("[ERROR] %0t retire_valid: got 1 expected 0 in a trap cycle",
                             $time);
                end
                // Fetch restarts at the trap target
                exp_pc = trap_target;
            end else if (retire_valid) begin
                check_retirement();
            end
        end
    end

    // Halt raises halt_req, then fetching stops and nothing more retires
    task automatic check_halt();
        int n;
        @(negedge clk);
        n = 0;
        while (!halt_req && n < HALT_WAIT) begin
            step_cycle();
            n++;
        end
        checks++;
        if (!halt_req) begin
            errors++;
            $display("halt_req did not rise within %0d cycles of the halt", HALT_WAIT);
        end
        n = 0;
        while (fetch_valid && n < HALT_WAIT) begin
            step_cycle();
            n++;
        end
        checks++;
        if (fetch_valid) begin
            errors++;
            $display("fetch_valid stayed high %0d cycles after halt_req", HALT_WAIT);
        end
        // Any retirement in this window is caught by the retirement checker
        repeat (QUIET_CYCLES) begin
            step_cycle();
            checks++;
            if (fetch_valid !== 1'b0) begin
                errors++;
                $display("[ERROR] %0t fetch_valid: got %b expected 0", $time, fetch_valid);
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n         = 1'b0;
        imem_stall    = 1'b1;
        s2_hold       = 1'b0;
        trap_occurred = 1'b0;
        trap_target   = '0;
        load_en       = 1'b0;
        load_addr     = '0;
        load_data     = '0;
        halt_retired  = 1'b0;
        retired_count = 0;
        jump_count    = 0;
        trap_count    = 0;
        checks        = 0;
        errors        = 0;
        exp_pc        = fetch_pkg::RESET_PC;
        build_program();

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // imem_stall is still high here, so nothing is fetched until the image is in
        load_program();

        wait_cycles = 0;
        while (!halt_retired && retired_count < MAX_RETIRE && wait_cycles < RUN_CYCLES) begin
            @(posedge clk);
            drive_random_inputs();
            wait_cycles++;
        end

        if (!halt_retired && retired_count < MAX_RETIRE) begin
            errors++;
            $display("Timed out after %0d cycles with only %0d retirements",
                     RUN_CYCLES, retired_count);
        end else if (halt_retired) begin
            check_halt();
        end

        $display("Retired %0d, jumps %0d, traps %0d, halt at word %0d, checks %0d, errors %0d",
                 retired_count, jump_count, trap_count, halt_index, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : tb_fetch

//--- build.f
+incdir+sim
logic/fetch_pkg.sv
logic/fetch_stage.sv
logic/instr_mem.sv
logic/branch_unit.sv
logic/fetch_top.sv
sim/tb_fetch.sv
